/* logic/agc_cfg.svh */
`ifndef AGC_CFG_SVH
`define AGC_CFG_SVH

// word layout: bit 15 is the overflow copy, bit 14 the sign
`define AGC_WORD_W 16

// erasable memory, one flat address space
`define AGC_ADDR_W 10
`define AGC_MEM_DEPTH 1024

// central registers mapped at the bottom of memory
`define AGC_ADDR_A 0
`define AGC_ADDR_L 1
`define AGC_ADDR_Q 2
`define AGC_ADDR_Z 5

// first instruction fetched after reset
`define AGC_START_ADDR 16

// no interrupt vectors or fixed banks in this core

`endif

/* logic/agc_pkg.sv */
`include "agc_cfg.svh"

package agc_pkg;

  typedef logic [`AGC_WORD_W-1:0] agc_word_t;
  typedef logic [`AGC_ADDR_W-1:0] agc_addr_t;

  // basic opcode field, bits 14 to 12 of an instruction
  typedef enum logic [2:0] {
    OP_TC      = 3'd0,
    OP_TCF     = 3'd1,
    OP_INCR    = 3'd2,
    OP_CA      = 3'd3,
    OP_CS      = 3'd4,
    OP_TS_XCH  = 3'd5,
    OP_AD      = 3'd6,
    OP_MASK    = 3'd7
  } agc_opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_COM  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_INCR = 3'd3,
    ALU_PASS = 3'd4
  } alu_op_t;

  // which requester owns the memory
  typedef enum logic {
    REQ_HOST = 1'b0,
    REQ_SEQ  = 1'b1
  } req_idx_t;

endpackage

/* logic/ones_comp_alu.sv */
`timescale 1ns/1ps
`include "agc_cfg.svh"

module ones_comp_alu
  import agc_pkg::*;
(
  input  alu_op_t   op,
  input  agc_word_t a_word,
  input  agc_word_t operand,
  output agc_word_t result
);

  // magnitude plus sign, without the overflow copy
  localparam int MAG_W = `AGC_WORD_W - 1;

  logic [MAG_W:0]   raw_sum;
  logic [MAG_W-1:0] folded_sum;
  logic [MAG_W-1:0] incr_sum;
  logic             add_overflow;

  // carry out of the sign bit wraps back into bit 0
  assign raw_sum = {1'b0, a_word[MAG_W-1:0]} + {1'b0, operand[MAG_W-1:0]};
  assign folded_sum = raw_sum[MAG_W-1:0] + MAG_W'(raw_sum[MAG_W]);

  // like signs in, other sign out
  assign add_overflow = (a_word[MAG_W-1] == operand[MAG_W-1]) &&
                        (folded_sum[MAG_W-1] != a_word[MAG_W-1]);

  assign incr_sum = operand[MAG_W-1:0] + MAG_W'(1);

  always_comb
  begin
    case (op)
      ALU_ADD:
        result = {add_overflow, folded_sum};
      ALU_COM:
        result = {1'b0, ~operand[MAG_W-1:0]};
      // A's overflow copy never takes part in the mask
      ALU_AND:
        result = operand & {1'b0, a_word[MAG_W-1:0]};
      ALU_INCR:
        result = {1'b0, incr_sum};
      ALU_PASS:
        result = operand;
      default:
        result = operand;
    endcase
  end

endmodule

/* logic/word_memory.sv */
`timescale 1ns/1ps
`include "agc_cfg.svh"

module word_memory
  import agc_pkg::*;
(
  input  logic      raw_clk,
  input  logic      button_reset,
  input  logic      mem_en,
  input  logic      mem_we,
  input  agc_addr_t mem_addr,
  input  agc_word_t mem_wdata,
  output agc_word_t mem_rdata,
  output agc_word_t reg_a,
  output agc_word_t reg_z
);

  agc_word_t mem_array [`AGC_MEM_DEPTH];
  agc_word_t reg_l;
  agc_word_t reg_q;
  logic      wr_en;

  assign wr_en = mem_en && mem_we;

  // array keeps a copy of every word, central ones included
  always_ff @(posedge raw_clk)
  begin
    if (wr_en)
      mem_array[mem_addr] <= mem_wdata;
  end

  // central registers
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      reg_a <= '0;
      reg_l <= '0;
      reg_q <= '0;
      reg_z <= agc_word_t'(`AGC_START_ADDR);
    end
    else if (wr_en)
    begin
      case (mem_addr)
        agc_addr_t'(`AGC_ADDR_A): reg_a <= mem_wdata;
        agc_addr_t'(`AGC_ADDR_L): reg_l <= mem_wdata;
        agc_addr_t'(`AGC_ADDR_Q): reg_q <= mem_wdata;
        agc_addr_t'(`AGC_ADDR_Z): reg_z <= mem_wdata;
        default: ;
      endcase
    end
  end

  // mapped addresses read back from the live registers
  always_ff @(posedge raw_clk)
  begin
    if (mem_en)
    begin
      case (mem_addr)
        agc_addr_t'(`AGC_ADDR_A): mem_rdata <= reg_a;
        agc_addr_t'(`AGC_ADDR_L): mem_rdata <= reg_l;
        agc_addr_t'(`AGC_ADDR_Q): mem_rdata <= reg_q;
        agc_addr_t'(`AGC_ADDR_Z): mem_rdata <= reg_z;
        default:                  mem_rdata <= mem_array[mem_addr];
      endcase
    end
  end

  we_needs_en: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_we |-> mem_en);

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
  import agc_pkg::*;
(
  input  logic      raw_clk,
  input  logic      button_reset,
  input  logic      host_req,
  input  logic      host_we,
  input  agc_addr_t host_addr,
  input  agc_word_t host_wdata,
  output logic      host_ack,
  output agc_word_t host_rdata,
  input  logic      seq_req,
  input  logic      seq_we,
  input  agc_addr_t seq_addr,
  input  agc_word_t seq_wdata,
  output logic      seq_ack,
  output agc_word_t seq_rdata,
  output logic      mem_en,
  output logic      mem_we,
  output agc_addr_t mem_addr,
  output agc_word_t mem_wdata,
  input  agc_word_t mem_rdata
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_CAPTURE,
    ARB_ACK
  } arb_state_t;

  arb_state_t state;
  req_idx_t   grant;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state    <= ARB_IDLE;
      grant    <= REQ_HOST;
      mem_en   <= 1'b0;
      mem_we   <= 1'b0;
      host_ack <= 1'b0;
      seq_ack  <= 1'b0;
    end
    else
    begin
      case (state)
        // host wins a tie
        ARB_IDLE:
          if (host_req)
          begin
            grant     <= REQ_HOST;
            mem_en    <= 1'b1;
            mem_we    <= host_we;
            mem_addr  <= host_addr;
            mem_wdata <= host_wdata;
            state     <= ARB_ACCESS;
          end
          else if (seq_req)
          begin
            grant     <= REQ_SEQ;
            mem_en    <= 1'b1;
            mem_we    <= seq_we;
            mem_addr  <= seq_addr;
            mem_wdata <= seq_wdata;
            state     <= ARB_ACCESS;
          end
        // memory acts on this edge
        ARB_ACCESS:
        begin
          mem_en <= 1'b0;
          mem_we <= 1'b0;
          state  <= ARB_CAPTURE;
        end
        ARB_CAPTURE:
        begin
          if (grant == REQ_HOST)
          begin
            host_rdata <= mem_rdata;
            host_ack   <= 1'b1;
          end
          else
          begin
            seq_rdata <= mem_rdata;
            seq_ack   <= 1'b1;
          end
          state <= ARB_ACK;
        end
        // grant held until the requester lets go
        ARB_ACK:
          if (grant == REQ_HOST && !host_req)
          begin
            host_ack <= 1'b0;
            state    <= ARB_IDLE;
          end
          else if (grant == REQ_SEQ && !seq_req)
          begin
            seq_ack <= 1'b0;
            state   <= ARB_IDLE;
          end
        default:
          state <= ARB_IDLE;
      endcase
    end
  end

  acks_exclusive: assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(host_ack && seq_ack));

  host_ack_after_req: assert property (@(posedge raw_clk) disable iff (!button_reset)
    $rose(host_ack) |-> host_req);

  seq_ack_after_req: assert property (@(posedge raw_clk) disable iff (!button_reset)
    $rose(seq_ack) |-> seq_req);

endmodule

/* logic/instr_sequencer.sv */
`timescale 1ns/1ps
`include "agc_cfg.svh"

module instr_sequencer
  import agc_pkg::*;
(
  input  logic      raw_clk,
  input  logic      button_reset,
  input  logic      run,
  output logic      halted,
  output logic      seq_req,
  output logic      seq_we,
  output agc_addr_t seq_addr,
  output agc_word_t seq_wdata,
  input  logic      seq_ack,
  input  agc_word_t seq_rdata,
  input  agc_word_t reg_a,
  input  agc_word_t reg_z,
  output alu_op_t   alu_op,
  output agc_word_t alu_operand,
  input  agc_word_t alu_result
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_FETCH,
    S_INC_Z,
    S_DECODE,
    S_READ_EA,
    S_EXEC,
    S_WRITEBACK,
    S_WAIT_ACK,
    S_WAIT_LOW,
    S_HALT
  } seq_state_t;

  seq_state_t  state;
  seq_state_t  ret_state;
  logic        extra_code;
  logic        do_xch;
  agc_word_t   instr;
  agc_word_t   bus_data;
  agc_word_t   wb_data;
  agc_addr_t   wb_addr;
  agc_opcode_t opcode;
  logic [1:0]  qc;
  agc_addr_t   k;
  agc_word_t   k_word;

  assign opcode = agc_opcode_t'(instr[14:12]);
  assign qc     = instr[11:10];
  assign k      = instr[`AGC_ADDR_W-1:0];
  assign k_word = {{(`AGC_WORD_W-`AGC_ADDR_W){1'b0}}, k};

  // operand read back last feeds the ALU
  assign alu_operand = bus_data;
  assign halted      = (state == S_HALT);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state      <= S_IDLE;
      ret_state  <= S_IDLE;
      seq_req    <= 1'b0;
      seq_we     <= 1'b0;
      extra_code <= 1'b0;
      do_xch     <= 1'b0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (run)
            state <= S_FETCH;
        S_FETCH:
        begin
          seq_req   <= 1'b1;
          seq_we    <= 1'b0;
          seq_addr  <= reg_z[`AGC_ADDR_W-1:0];
          ret_state <= S_INC_Z;
          state     <= S_WAIT_ACK;
        end
        S_INC_Z:
        begin
          instr     <= bus_data;
          seq_req   <= 1'b1;
          seq_we    <= 1'b1;
          seq_addr  <= agc_addr_t'(`AGC_ADDR_Z);
          seq_wdata <= reg_z + agc_word_t'(1);
          ret_state <= S_DECODE;
          state     <= S_WAIT_ACK;
        end
        S_DECODE:
        begin
          wb_addr <= agc_addr_t'(`AGC_ADDR_A);
          do_xch  <= 1'b0;
          state   <= S_READ_EA;
          if (extra_code)
          begin
            // only EDRUPT survives as an extracode, used as halt
            extra_code <= 1'b0;
            if (opcode == OP_TC && instr[11:9] == 3'b111)
              state <= S_HALT;
            else
              state <= S_FETCH;
          end
          else
          begin
            case (opcode)
              OP_TC:
                if (instr[11:0] == 12'd6)
                begin
                  extra_code <= 1'b1;
                  state      <= S_FETCH;
                end
                else
                begin
                  // Z already points past the TC, so Q gets the return address
                  seq_req   <= 1'b1;
                  seq_we    <= 1'b1;
                  seq_addr  <= agc_addr_t'(`AGC_ADDR_Q);
                  seq_wdata <= reg_z;
                  wb_addr   <= agc_addr_t'(`AGC_ADDR_Z);
                  wb_data   <= k_word;
                  ret_state <= S_WRITEBACK;
                  state     <= S_WAIT_ACK;
                end
              OP_TCF:
                if (qc != 2'd0)
                begin
                  wb_addr <= agc_addr_t'(`AGC_ADDR_Z);
                  wb_data <= k_word;
                  state   <= S_WRITEBACK;
                end
                else
                  state <= S_FETCH;
              OP_INCR:
                if (qc == 2'd2)
                begin
                  alu_op  <= ALU_INCR;
                  wb_addr <= k;
                end
                else
                  state <= S_FETCH;
              OP_CA:
                alu_op <= ALU_PASS;
              OP_CS:
                alu_op <= ALU_COM;
              OP_TS_XCH:
                if (qc == 2'd2)
                begin
                  wb_addr <= k;
                  wb_data <= reg_a;
                  state   <= S_WRITEBACK;
                end
                else if (qc == 2'd3)
                begin
                  alu_op <= ALU_PASS;
                  do_xch <= 1'b1;
                end
                else
                  state <= S_FETCH;
              OP_AD:
                alu_op <= ALU_ADD;
              OP_MASK:
                alu_op <= ALU_AND;
              default:
                state <= S_FETCH;
            endcase
          end
        end
        S_READ_EA:
        begin
          seq_req   <= 1'b1;
          seq_we    <= 1'b0;
          seq_addr  <= k;
          ret_state <= S_EXEC;
          state     <= S_WAIT_ACK;
        end
        S_EXEC:
        begin
          wb_data <= alu_result;
          if (do_xch)
          begin
            // old A goes to memory first, operand into A on writeback
            seq_req   <= 1'b1;
            seq_we    <= 1'b1;
            seq_addr  <= k;
            seq_wdata <= reg_a;
            ret_state <= S_WRITEBACK;
            state     <= S_WAIT_ACK;
          end
          else
            state <= S_WRITEBACK;
        end
        S_WRITEBACK:
        begin
          seq_req   <= 1'b1;
          seq_we    <= 1'b1;
          seq_addr  <= wb_addr;
          seq_wdata <= wb_data;
          ret_state <= S_FETCH;
          state     <= S_WAIT_ACK;
        end
        S_WAIT_ACK:
          if (seq_ack)
          begin
            seq_req  <= 1'b0;
            seq_we   <= 1'b0;
            bus_data <= seq_rdata;
            state    <= S_WAIT_LOW;
          end
        // next request waits for ack to clear
        S_WAIT_LOW:
          if (!seq_ack)
            state <= ret_state;
        S_HALT:
          state <= S_HALT;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  req_held_for_ack: assert property (@(posedge raw_clk) disable iff (!button_reset)
    $fell(seq_req) |-> $past(seq_ack));

endmodule

/* logic/agc_top.sv */
`timescale 1ns/1ps

module agc_top
  import agc_pkg::*;
(
  input  logic      raw_clk,
  input  logic      button_reset,
  input  logic      run,
  output logic      halted,
  input  logic      host_req,
  input  logic      host_we,
  input  agc_addr_t host_addr,
  input  agc_word_t host_wdata,
  output logic      host_ack,
  output agc_word_t host_rdata
);

  logic      seq_req;
  logic      seq_we;
  agc_addr_t seq_addr;
  agc_word_t seq_wdata;
  logic      seq_ack;
  agc_word_t seq_rdata;
  logic      mem_en;
  logic      mem_we;
  agc_addr_t mem_addr;
  agc_word_t mem_wdata;
  agc_word_t mem_rdata;
  agc_word_t reg_a;
  agc_word_t reg_z;
  alu_op_t   alu_op;
  agc_word_t alu_operand;
  agc_word_t alu_result;

  instr_sequencer seq_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .halted       (halted),
    .seq_req      (seq_req),
    .seq_we       (seq_we),
    .seq_addr     (seq_addr),
    .seq_wdata    (seq_wdata),
    .seq_ack      (seq_ack),
    .seq_rdata    (seq_rdata),
    .reg_a        (reg_a),
    .reg_z        (reg_z),
    .alu_op       (alu_op),
    .alu_operand  (alu_operand),
    .alu_result   (alu_result)
  );

  mem_arbiter arb_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .host_req     (host_req),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata),
    .seq_req      (seq_req),
    .seq_we       (seq_we),
    .seq_addr     (seq_addr),
    .seq_wdata    (seq_wdata),
    .seq_ack      (seq_ack),
    .seq_rdata    (seq_rdata),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata)
  );

  // A and Z taps bypass the arbiter
  word_memory mem_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .reg_a        (reg_a),
    .reg_z        (reg_z)
  );

  ones_comp_alu alu_i (
    .op           (alu_op),
    .a_word       (reg_a),
    .operand      (alu_operand),
    .result       (alu_result)
  );

endmodule

/* testbench/tb_agc_tasks.svh */
`ifndef TB_AGC_TASKS_SVH
`define TB_AGC_TASKS_SVH

// four-phase host write, inputs change on the rising edge
task automatic host_write(input agc_addr_t addr, input agc_word_t data);
  @(posedge raw_clk);
  host_req   <= 1'b1;
  host_we    <= 1'b1;
  host_addr  <= addr;
  host_wdata <= data;
  do
    @(posedge raw_clk);
  while (!host_ack);
  host_req <= 1'b0;
  host_we  <= 1'b0;
  do
    @(posedge raw_clk);
  while (host_ack);
endtask

// read data is valid in the cycle that ack shows
task automatic host_read(input agc_addr_t addr, output agc_word_t data);
  @(posedge raw_clk);
  host_req  <= 1'b1;
  host_we   <= 1'b0;
  host_addr <= addr;
  do
    @(posedge raw_clk);
  while (!host_ack);
  data = host_rdata;
  host_req <= 1'b0;
  do
    @(posedge raw_clk);
  while (host_ack);
endtask

// opcode in 14..12, qualifier in 11..10, address below
function automatic agc_word_t encode_instr(input logic [2:0] op, input logic [1:0] qc,
                                           input agc_addr_t addr);
  return {1'b0, op, qc, addr};
endfunction

task automatic append_instr(input logic [2:0] op, input logic [1:0] qc, input agc_addr_t addr);
  prog.push_back(encode_instr(op, qc, addr));
endtask

// EXTEND, then the EDRUPT pattern with bits 11..9 set
task automatic append_halt();
  prog.push_back(encode_instr(OPC_TC, 2'd0, agc_addr_t'(6)));
  prog.push_back(encode_instr(OPC_TC, 2'd3, agc_addr_t'(10'h200)));
endtask

task automatic load_program();
  foreach (prog[i])
    host_write(agc_addr_t'(START + i), prog[i]);
endtask

// reference model, 15-bit ones complement with overflow copy in bit 15
function automatic agc_word_t add_ones_comp(input agc_word_t a, input agc_word_t b);
  logic [15:0] sum;
  logic        ovf;
  sum = {1'b0, a[14:0]} + {1'b0, b[14:0]};
  // end-around carry
  if (sum[15])
    sum = {1'b0, sum[14:0]} + 16'd1;
  ovf = (a[14] == b[14]) && (sum[14] != a[14]);
  return {ovf, sum[14:0]};
endfunction

function automatic agc_word_t complement_word(input agc_word_t w);
  return {1'b0, ~w[14:0]};
endfunction

function automatic agc_word_t mask_word(input agc_word_t a, input agc_word_t w);
  return w & {1'b0, a[14:0]};
endfunction

function automatic agc_word_t increment_word(input agc_word_t w);
  return {1'b0, w[14:0] + 15'd1};
endfunction

// xorshift32
function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

`endif

/* testbench/tb_agc.sv */
`timescale 1ns/1ps
`include "agc_cfg.svh"

module tb_agc
  import agc_pkg::*;
();

  localparam logic [2:0] OPC_TC     = 3'd0;
  localparam logic [2:0] OPC_TCF    = 3'd1;
  localparam logic [2:0] OPC_INCR   = 3'd2;
  localparam logic [2:0] OPC_CA     = 3'd3;
  localparam logic [2:0] OPC_CS     = 3'd4;
  localparam logic [2:0] OPC_TS_XCH = 3'd5;
  localparam logic [2:0] OPC_AD     = 3'd6;
  localparam logic [2:0] OPC_MASK   = 3'd7;

  localparam int        START       = `AGC_START_ADDR;
  localparam agc_addr_t DATA_BASE   = 10'h200;
  localparam agc_addr_t RESULT_BASE = 10'h300;

  // executed instructions in tests 2 to 6
  localparam int INSTR_COUNT = 11 + 7 + 9 + 4 + 11;
  // host accesses in tests 1 to 6 with the reads during the run
  localparam int HOST_COUNT  = 19 + 20 + 13 + 19 + 12 + 32;
  localparam int CYCLE_LIMIT = (INSTR_COUNT * 30 + HOST_COUNT * 6) * 2;

  logic      raw_clk;
  logic      button_reset;
  logic      run;
  logic      halted;
  logic      host_req;
  logic      host_we;
  agc_addr_t host_addr;
  agc_word_t host_wdata;
  logic      host_ack;
  agc_word_t host_rdata;

  int          errors;
  int          checks;
  int          tests_done;
  int          errors_at_start;
  int          cycle_count;
  int          idx;
  logic [31:0] rng_state;
  agc_word_t   prog [$];
  agc_word_t   opnd [6];
  agc_word_t   got;
  agc_word_t   wdata;
  agc_addr_t   addr;

  agc_top dut_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .halted       (halted),
    .host_req     (host_req),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata)
  );

  `include "tb_agc_tasks.svh"

  always #20 raw_clk = ~raw_clk;

  always @(posedge raw_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish");
      $display("Done: errors found");
      $finish;
    end
  end

  // four-phase rules on the host port
  host_ack_needs_req: assert property (@(posedge raw_clk) disable iff (!button_reset)
      $rose(host_ack) |-> host_req)
    else
    begin
      $display("handshake error at %0t ns: host_ack rose without host_req", $time);
      errors = errors + 1;
    end

  host_ack_drops_late: assert property (@(posedge raw_clk) disable iff (!button_reset)
      $fell(host_ack) |-> !$past(host_req))
    else
    begin
      $display("handshake error at %0t ns: host_ack fell while host_req was high", $time);
      errors = errors + 1;
    end

  // sequencer port
  seq_ack_needs_req: assert property (@(posedge raw_clk) disable iff (!button_reset)
      $rose(dut_i.seq_ack) |-> dut_i.seq_req)
    else
    begin
      $display("handshake error at %0t ns: seq_ack rose without seq_req", $time);
      errors = errors + 1;
    end

  seq_ack_drops_late: assert property (@(posedge raw_clk) disable iff (!button_reset)
      $fell(dut_i.seq_ack) |-> !$past(dut_i.seq_req))
    else
    begin
      $display("handshake error at %0t ns: seq_ack fell while seq_req was high", $time);
      errors = errors + 1;
    end

  halted_sticky: assert property (@(posedge raw_clk) disable iff (!button_reset)
      halted |=> halted)
    else
    begin
      $display("halted dropped before reset at %0t ns", $time);
      errors = errors + 1;
    end

  task automatic check_word(input string what, input agc_word_t got_w, input agc_word_t exp_w);
    checks = checks + 1;
    assert (got_w === exp_w)
    else
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got_w, exp_w);
      errors = errors + 1;
    end
  endtask

  task automatic apply_reset();
    @(posedge raw_clk);
    button_reset <= 1'b0;
    repeat (2) @(posedge raw_clk);
    button_reset <= 1'b1;
  endtask

  task automatic run_until_halt();
    @(posedge raw_clk);
    run <= 1'b1;
    @(posedge raw_clk);
    run <= 1'b0;
    do
      @(posedge raw_clk);
    while (!halted);
  endtask

  task automatic finish_test(input string name);
    tests_done = tests_done + 1;
    $display("test %0d %s: %0d errors", tests_done, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // three CA, AD, TS groups over fresh operands
  task automatic prepare_sum_program();
    prog.delete();
    for (int i = 0; i < 3; i++)
    begin
      opnd[2*i]   = agc_word_t'(next_random());
      opnd[2*i+1] = agc_word_t'(next_random());
      host_write(DATA_BASE + agc_addr_t'(2*i), opnd[2*i]);
      host_write(DATA_BASE + agc_addr_t'(2*i+1), opnd[2*i+1]);
      append_instr(OPC_CA, 2'd0, DATA_BASE + agc_addr_t'(2*i));
      append_instr(OPC_AD, 2'd0, DATA_BASE + agc_addr_t'(2*i+1));
      append_instr(OPC_TS_XCH, 2'd2, RESULT_BASE + agc_addr_t'(i));
    end
    append_halt();
    load_program();
  endtask

  task automatic check_sums();
    agc_word_t r;
    for (int i = 0; i < 3; i++)
    begin
      host_read(RESULT_BASE + agc_addr_t'(i), r);
      check_word("stored sum", r, add_ones_comp(opnd[2*i], opnd[2*i+1]));
    end
  endtask

  initial
  begin
    raw_clk         = 1'b0;
    button_reset    = 1'b0;
    run             = 1'b0;
    host_req        = 1'b0;
    host_we         = 1'b0;
    host_addr       = '0;
    host_wdata      = '0;
    errors          = 0;
    checks          = 0;
    tests_done      = 0;
    errors_at_start = 0;
    cycle_count     = 0;
    rng_state       = 32'he2da_50dd;

    // plain host access while the core waits
    apply_reset();
    host_read(agc_addr_t'(`AGC_ADDR_Z), got);
    check_word("Z after reset", got, agc_word_t'(START));
    wdata = agc_word_t'(next_random());
    host_write(agc_addr_t'(`AGC_ADDR_A), wdata);
    host_read(agc_addr_t'(`AGC_ADDR_A), got);
    check_word("A read back", got, wdata);
    for (int i = 0; i < 8; i++)
    begin
      addr  = agc_addr_t'(next_random());
      wdata = agc_word_t'(next_random());
      host_write(addr, wdata);
      host_read(addr, got);
      check_word("host read back", got, wdata);
    end
    finish_test("host write and read");

    apply_reset();
    prepare_sum_program();
    run_until_halt();
    check_sums();
    finish_test("CA AD TS program");

    // magnitudes of at least 0x2000 overflow in either sign
    apply_reset();
    prog.delete();
    opnd[0] = 16'h2000 | (agc_word_t'(next_random()) & 16'h1fff);
    opnd[1] = 16'h2000 | (agc_word_t'(next_random()) & 16'h1fff);
    opnd[2] = 16'h7fff ^ (16'h2000 | (agc_word_t'(next_random()) & 16'h1fff));
    opnd[3] = 16'h7fff ^ (16'h2000 | (agc_word_t'(next_random()) & 16'h1fff));
    for (int i = 0; i < 4; i++)
      host_write(DATA_BASE + agc_addr_t'(i), opnd[i]);
    append_instr(OPC_CA, 2'd0, DATA_BASE);
    append_instr(OPC_AD, 2'd0, DATA_BASE + agc_addr_t'(1));
    append_instr(OPC_TS_XCH, 2'd2, RESULT_BASE);
    append_instr(OPC_CA, 2'd0, DATA_BASE + agc_addr_t'(2));
    append_instr(OPC_AD, 2'd0, DATA_BASE + agc_addr_t'(3));
    append_halt();
    load_program();
    run_until_halt();
    host_read(RESULT_BASE, got);
    check_word("positive sum", got, add_ones_comp(opnd[0], opnd[1]));
    check_word("positive overflow bit", agc_word_t'(got[15]), 16'd1);
    host_read(agc_addr_t'(`AGC_ADDR_A), got);
    check_word("negative sum in A", got, add_ones_comp(opnd[2], opnd[3]));
    check_word("negative overflow bit", agc_word_t'(got[15]), 16'd1);
    finish_test("AD overflow");

    apply_reset();
    prog.delete();
    for (int i = 0; i < 5; i++)
    begin
      opnd[i] = agc_word_t'(next_random());
      host_write(DATA_BASE + agc_addr_t'(i), opnd[i]);
    end
    append_instr(OPC_CA, 2'd0, DATA_BASE);
    append_instr(OPC_MASK, 2'd0, DATA_BASE + agc_addr_t'(1));
    append_instr(OPC_TS_XCH, 2'd2, RESULT_BASE);
    append_instr(OPC_CS, 2'd0, DATA_BASE + agc_addr_t'(2));
    append_instr(OPC_TS_XCH, 2'd2, RESULT_BASE + agc_addr_t'(1));
    append_instr(OPC_INCR, 2'd2, DATA_BASE + agc_addr_t'(3));
    append_instr(OPC_TS_XCH, 2'd3, DATA_BASE + agc_addr_t'(4));
    append_halt();
    load_program();
    run_until_halt();
    host_read(RESULT_BASE, got);
    check_word("MASK result", got, mask_word(opnd[0], opnd[1]));
    host_read(RESULT_BASE + agc_addr_t'(1), got);
    check_word("CS result", got, complement_word(opnd[2]));
    host_read(DATA_BASE + agc_addr_t'(3), got);
    check_word("INCR word", got, increment_word(opnd[3]));
    // XCH swaps the complemented A with the last operand
    host_read(DATA_BASE + agc_addr_t'(4), got);
    check_word("XCH memory word", got, complement_word(opnd[2]));
    host_read(agc_addr_t'(`AGC_ADDR_A), got);
    check_word("XCH A", got, opnd[4]);
    finish_test("CS MASK INCR XCH");

    // TC to 20, TCF from 20 over the INCR at 21
    apply_reset();
    prog.delete();
    opnd[0] = agc_word_t'(next_random());
    host_write(DATA_BASE, opnd[0]);
    append_instr(OPC_TC, 2'd0, agc_addr_t'(START + 4));
    for (int i = 0; i < 3; i++)
      prog.push_back('0);
    append_instr(OPC_TCF, 2'd1, agc_addr_t'(START + 6));
    append_instr(OPC_INCR, 2'd2, DATA_BASE);
    append_halt();
    load_program();
    run_until_halt();
    host_read(agc_addr_t'(`AGC_ADDR_Q), got);
    check_word("Q after TC", got, agc_word_t'(START + 1));
    host_read(DATA_BASE, got);
    check_word("word behind TCF", got, opnd[0]);
    host_read(agc_addr_t'(`AGC_ADDR_Z), got);
    check_word("Z after halt", got, agc_word_t'(START + 8));
    finish_test("TC and TCF");

    // host traffic competes with the running core
    apply_reset();
    prepare_sum_program();
    fork
      run_until_halt();
      begin
        for (int i = 0; i < 12; i++)
        begin
          idx = next_random() % 6;
          host_read(DATA_BASE + agc_addr_t'(idx), got);
          check_word("operand read during run", got, opnd[idx]);
        end
      end
    join
    check_sums();
    finish_test("host reads during run");

    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* sources.f */
+incdir+logic
+incdir+testbench
logic/agc_pkg.sv
logic/ones_comp_alu.sv
logic/word_memory.sv
logic/mem_arbiter.sv
logic/instr_sequencer.sv
logic/agc_top.sv
testbench/tb_agc.sv
